/* verification/periph_tests.txt */
# name op(rd/wr) addr wdata gpio_i ext_irq_i exp_rdata exp_err exp_gpio_o exp_gpio_oe_o exp_irq_o exp_msip_o
# All numbers hex; exp_rdata is not checked on writes
reset_out_rd      rd 20000000 00000000 00 0 00000000 0 00 00 0 0
gpio_out_wr       wr 20000000 000000a5 00 0 00000000 0 a5 00 0 0
gpio_oe_wr        wr 20000004 0000003c 00 0 00000000 0 a5 3c 0 0
gpio_out_rd       rd 20000000 00000000 00 0 000000a5 0 a5 3c 0 0
gpio_oe_rd        rd 20000004 00000000 00 0 0000003c 0 a5 3c 0 0
gpio_in_rd        rd 20000008 00000000 5a 0 0000005a 0 a5 3c 0 0
gpio_status_ie0   rd 20000010 00000000 5a 0 00000000 0 a5 3c 0 0
gpio_ie_wr        wr 2000000c 0000000f 5a 0 00000000 0 a5 3c 0 0
gpio_ie_rd        rd 2000000c 00000000 5a 0 0000000f 0 a5 3c 0 0
gpio_status_rd    rd 20000010 00000000 5a 0 0000000a 0 a5 3c 0 0
gpio_status_wr    wr 20000010 ffffffff 5a 0 00000000 0 a5 3c 0 0
gpio_status_chk   rd 20000010 00000000 5a 0 0000000a 0 a5 3c 0 0
gpio_unmapped_rd  rd 20000014 00000000 5a 0 00000000 0 a5 3c 0 0
adder_a_wr        wr 20001000 12345678 5a 0 00000000 0 a5 3c 0 0
adder_b_wr        wr 20001004 11111111 5a 0 00000000 0 a5 3c 0 0
adder_sum_rd      rd 20001008 00000000 5a 0 23456789 0 a5 3c 0 0
adder_a_carry     wr 20001000 ffffff00 5a 0 00000000 0 a5 3c 0 0
adder_b_carry     wr 20001004 00000200 5a 0 00000000 0 a5 3c 0 0
adder_sum_carry   rd 20001008 00000000 5a 0 00000100 0 a5 3c 0 0
adder_sum_wr      wr 20001008 aaaaaaaa 5a 0 00000000 0 a5 3c 0 0
adder_sum_chk     rd 20001008 00000000 5a 0 00000100 0 a5 3c 0 0
adder_b_rd        rd 20001004 00000000 5a 0 00000200 0 a5 3c 0 0
irq_ie_wr         wr 20002000 00000f0a 5a 0 00000000 0 a5 3c 1 0
irq_ie_rd         rd 20002000 00000000 5a 0 00000f0a 0 a5 3c 1 0
irq_pending_gpio  rd 20002004 00000000 5a 0 0000000a 0 a5 3c 1 0
irq_claim_gpio    rd 20002008 00000000 5a 0 00000002 0 a5 3c 1 0
irq_masked        rd 20002004 00000000 04 0 00000000 0 a5 3c 0 0
irq_pending_ext   rd 20002004 00000000 00 4 00000400 0 a5 3c 1 0
irq_claim_ext     rd 20002008 00000000 00 4 0000000b 0 a5 3c 1 0
irq_claim_mixed   rd 20002008 00000000 08 6 00000004 0 a5 3c 1 0
irq_pending_mixed rd 20002004 00000000 08 6 00000608 0 a5 3c 1 0
irq_claim_none    rd 20002008 00000000 00 0 00000000 0 a5 3c 0 0
msip_set          wr 2000200c 00000001 00 0 00000000 0 a5 3c 0 1
msip_rd           rd 2000200c 00000000 00 0 00000001 0 a5 3c 0 1
msip_clr          wr 2000200c 00000000 00 0 00000000 0 a5 3c 0 0
err_base_wr       wr 30000000 000000ff 00 0 00000000 1 a5 3c 0 0
err_base_rd       rd 30000008 00000000 00 0 deadbeef 1 a5 3c 0 0
err_base_adder_wr wr 10001000 00000055 00 0 00000000 1 a5 3c 0 0
err_sel_wr        wr 20003000 000000ff 00 0 00000000 1 a5 3c 0 0
err_sel_rd        rd 2000f004 00000000 00 0 deadbeef 1 a5 3c 0 0
err_align_wr      wr 20000006 000000ff 00 0 00000000 1 a5 3c 0 0
err_align_rd      rd 20001001 00000000 00 0 deadbeef 1 a5 3c 0 0
chk_out_after_err rd 20000000 00000000 00 0 000000a5 0 a5 3c 0 0
chk_oe_after_err  rd 20000004 00000000 00 0 0000003c 0 a5 3c 0 0
chk_a_after_err   rd 20001000 00000000 00 0 ffffff00 0 a5 3c 0 0

/* project.f */
+incdir+logic
logic/periph_pkg.sv
logic/obi_reg_bridge.sv
logic/periph_decoder.sv
logic/gpio_regs.sv
logic/add_two_number.sv
logic/irq_ctrl.sv
logic/periph_subsystem.sv
verification/tb_periph_subsystem.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# The exit status is nonzero when the simulation fails.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f project.f \
  --top-module tb_periph_subsystem

./obj_dir/Vtb_periph_subsystem

/* verification/tb_periph_subsystem.sv */
// ------------------------------
// Testbench for the peripheral subsystem.
// Runs the bus and pin cases listed in the test file.
// ------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module tb_periph_subsystem;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  req;
  logic                  we;
  logic [31:0]           addr;
  logic [31:0]           wdata;
  logic                  gnt;
  logic                  rvalid;
  logic [31:0]           rdata;
  logic                  err;
  logic [`GPIO_W-1:0]    gpio;
  logic [`GPIO_W-1:0]    gpio_o;
  logic [`GPIO_W-1:0]    gpio_oe_o;
  logic [`EXT_IRQ_W-1:0] ext_irq;
  logic                  irq_o;
  logic                  msip_o;

  string lines[$];
  int    cycle_cnt = 0;
  int    cycle_limit = 0;
  logic  accepted_prev = 1'b0;

  periph_subsystem u_dut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .req_i     (req),
    .we_i      (we),
    .addr_i    (addr),
    .wdata_i   (wdata),
    .gnt_o     (gnt),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .err_o     (err),
    .gpio_i    (gpio),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .ext_irq_i (ext_irq),
    .irq_o     (irq_o),
    .msip_o    (msip_o)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("ERROR %s: expected 0x%08h, actual 0x%08h", what, expected, actual));
    end
  endtask

  // Every accepted request gives rvalid in the very next cycle, and only then
  always @(posedge clk) begin
    check_value("grant_rvalid", 32'(accepted_prev), 32'(rvalid));
    accepted_prev = req & gnt;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      abort_run("timeout waiting for bus response");
    end
  end

  task automatic load_tests();
    int    fd;
    string line;
    fd = $fopen("verification/periph_tests.txt", "r");
    if (fd == 0) begin
      abort_run("could not open verification/periph_tests.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    if (lines.size() == 0) begin
      abort_run("no test lines found in the test file");
    end
  endtask

  task automatic run_line(input string line);
    logic [8*24-1:0] name;
    logic [15:0]     op;
    logic [31:0]     addr_v;
    logic [31:0]     wdata_v;
    logic [31:0]     gpio_v;
    logic [31:0]     ext_v;
    logic [31:0]     exp_rdata;
    logic [31:0]     exp_err;
    logic [31:0]     exp_gpio;
    logic [31:0]     exp_oe;
    logic [31:0]     exp_irq;
    logic [31:0]     exp_msip;
    string           tname;
    int              cnt;
    cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h", name, op, addr_v, wdata_v,
                  gpio_v, ext_v, exp_rdata, exp_err, exp_gpio, exp_oe, exp_irq, exp_msip);
    if (cnt != 12 || (op != "rd" && op != "wr")) begin
      abort_run($sformatf("malformed test line: %s", line));
    end
    tname = $sformatf("%0s", name);

    // Pins first, long enough for the input synchronizer
    @(negedge clk);
    gpio    = gpio_v[`GPIO_W-1:0];
    ext_irq = ext_v[`EXT_IRQ_W-1:0];
    repeat (4) @(negedge clk);

    req   = 1'b1;
    we    = (op == "wr");
    addr  = addr_v;
    wdata = wdata_v;
    while (!gnt) @(negedge clk);
    @(negedge clk);
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    while (!rvalid) @(negedge clk);
    check_value({tname, " gnt_o"}, 32'd0, 32'(gnt));
    if (op == "rd") begin
      check_value({tname, " rdata"}, exp_rdata, rdata);
    end
    check_value({tname, " err"}, exp_err, 32'(err));

    @(negedge clk);
    check_value({tname, " gpio_o"}, exp_gpio, 32'(gpio_o));
    check_value({tname, " gpio_oe_o"}, exp_oe, 32'(gpio_oe_o));
    check_value({tname, " irq_o"}, exp_irq, 32'(irq_o));
    check_value({tname, " msip_o"}, exp_msip, 32'(msip_o));
  endtask

  initial begin
    rst_n   = 1'b0;
    req     = 1'b0;
    we      = 1'b0;
    addr    = '0;
    wdata   = '0;
    gpio    = '0;
    ext_irq = '0;

    load_tests();
    cycle_limit = 12 * lines.size() + 50;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset gnt_o", 32'd1, 32'(gnt));
    check_value("reset rvalid_o", 32'd0, 32'(rvalid));
    check_value("reset irq_o", 32'd0, 32'(irq_o));
    check_value("reset msip_o", 32'd0, 32'(msip_o));
    check_value("reset gpio_o", 32'd0, 32'(gpio_o));
    check_value("reset gpio_oe_o", 32'd0, 32'(gpio_oe_o));

    foreach (lines[i]) begin
      run_line(lines[i]);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule : tb_periph_subsystem

`default_nettype wire

/* logic/periph_subsystem.sv */
// -----------------------------
// Peripheral subsystem top: bus bridge, decoder, peripherals.
// One bus port in, GPIO pins and interrupts out.
// -----------------------------
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module periph_subsystem (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [31:0]           addr_i,
  input  logic [31:0]           wdata_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output logic [31:0]           rdata_o,
  output logic                  err_o,

  input  logic [`GPIO_W-1:0]    gpio_i,
  output logic [`GPIO_W-1:0]    gpio_o,
  output logic [`GPIO_W-1:0]    gpio_oe_o,

  input  logic [`EXT_IRQ_W-1:0] ext_irq_i,
  output logic                  irq_o,
  output logic                  msip_o
);

  import periph_pkg::*;

  logic               acc_valid;
  logic               acc_we;
  periph_addr_u       acc_addr;
  logic [31:0]        acc_wdata;
  logic [31:0]        rsp_rdata;
  logic               rsp_err;

  logic               sel_gpio;
  logic               sel_adder;
  logic               sel_irq;
  logic               reg_we;
  reg_off_t           reg_off;
  logic [31:0]        reg_wdata;
  logic [31:0]        gpio_rdata;
  logic [31:0]        adder_rdata;
  logic [31:0]        irq_rdata;
  logic [`GPIO_W-1:0] gpio_irq;

  obi_reg_bridge u_bridge (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .acc_valid_o (acc_valid),
    .acc_we_o    (acc_we),
    .acc_addr_o  (acc_addr),
    .acc_wdata_o (acc_wdata),
    .rsp_rdata_i (rsp_rdata),
    .rsp_err_i   (rsp_err),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o)
  );

  periph_decoder u_decoder (
    .acc_valid_i   (acc_valid),
    .acc_we_i      (acc_we),
    .acc_addr_i    (acc_addr),
    .acc_wdata_i   (acc_wdata),
    .sel_gpio_o    (sel_gpio),
    .sel_adder_o   (sel_adder),
    .sel_irq_o     (sel_irq),
    .we_o          (reg_we),
    .reg_off_o     (reg_off),
    .wdata_o       (reg_wdata),
    .gpio_rdata_i  (gpio_rdata),
    .adder_rdata_i (adder_rdata),
    .irq_rdata_i   (irq_rdata),
    .rsp_rdata_o   (rsp_rdata),
    .rsp_err_o     (rsp_err)
  );

  gpio_regs u_gpio (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sel_i      (sel_gpio),
    .we_i       (reg_we),
    .reg_off_i  (reg_off),
    .wdata_i    (reg_wdata),
    .rdata_o    (gpio_rdata),
    .gpio_i     (gpio_i),
    .gpio_o     (gpio_o),
    .gpio_oe_o  (gpio_oe_o),
    .gpio_irq_o (gpio_irq)
  );

  add_two_number u_adder (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .sel_i     (sel_adder),
    .we_i      (reg_we),
    .reg_off_i (reg_off),
    .wdata_i   (reg_wdata),
    .rdata_o   (adder_rdata)
  );

  irq_ctrl u_irq (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sel_i      (sel_irq),
    .we_i       (reg_we),
    .reg_off_i  (reg_off),
    .wdata_i    (reg_wdata),
    .rdata_o    (irq_rdata),
    .gpio_irq_i (gpio_irq),
    .ext_irq_i  (ext_irq_i),
    .irq_o      (irq_o),
    .msip_o     (msip_o)
  );

endmodule : periph_subsystem

`default_nettype wire

/* logic/irq_ctrl.sv */
// -----------------------------
// Level interrupt controller with claim and software irq.
// GPIO sources sit below the external ones.
// -----------------------------
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module irq_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  logic                  sel_i,
  input  logic                  we_i,
  input  periph_pkg::reg_off_t  reg_off_i,
  input  logic [31:0]           wdata_i,
  output logic [31:0]           rdata_o,

  input  logic [`GPIO_W-1:0]    gpio_irq_i,
  input  logic [`EXT_IRQ_W-1:0] ext_irq_i,
  output logic                  irq_o,
  output logic                  msip_o
);

  localparam int SRC_W = `GPIO_W + `EXT_IRQ_W;
  localparam int PAD_W = 32 - SRC_W;

  logic [SRC_W-1:0] src;
  logic [SRC_W-1:0] ie_q;
  logic [SRC_W-1:0] pending;
  logic             msip_q;
  logic [31:0]      claim;

  assign src     = {ext_irq_i, gpio_irq_i};
  assign pending = src & ie_q;

  // PENDING and CLAIM writes have no effect
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ie_q   <= '0;
      msip_q <= 1'b0;
    end else if (sel_i && we_i) begin
      case (reg_off_i)
        `IRQ_IE_OFF:   ie_q   <= wdata_i[SRC_W-1:0];
        `IRQ_MSIP_OFF: msip_q <= wdata_i[0];
        default: ;
      endcase
    end
  end

  // Scan from the top so the lowest pending index wins, 0 means none
  always_comb begin
    claim = '0;
    for (int i = SRC_W - 1; i >= 0; i--) begin
      if (pending[i]) begin
        claim = 32'(i + 1);
      end
    end
  end

  always_comb begin
    case (reg_off_i)
      `IRQ_IE_OFF:      rdata_o = {{PAD_W{1'b0}}, ie_q};
      `IRQ_PENDING_OFF: rdata_o = {{PAD_W{1'b0}}, pending};
      `IRQ_CLAIM_OFF:   rdata_o = claim;
      `IRQ_MSIP_OFF:    rdata_o = {31'b0, msip_q};
      default:          rdata_o = '0;
    endcase
  end

  assign irq_o  = |pending;
  assign msip_o = msip_q;

endmodule : irq_ctrl

`default_nettype wire

/* logic/add_two_number.sv */
// -----------------------------
// Adder peripheral: write A and B, read their sum.
// -----------------------------
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module add_two_number (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 sel_i,
  input  logic                 we_i,
  input  periph_pkg::reg_off_t reg_off_i,
  input  logic [31:0]          wdata_i,
  output logic [31:0]          rdata_o
);

  logic [31:0] a_q;
  logic [31:0] b_q;
  logic [31:0] sum;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_q <= '0;
      b_q <= '0;
    end else if (sel_i && we_i) begin
      case (reg_off_i)
        `ADDER_A_OFF: a_q <= wdata_i;
        `ADDER_B_OFF: b_q <= wdata_i;
        default: ;
      endcase
    end
  end

  // Carry out is dropped
  assign sum = a_q + b_q;

  always_comb begin
    case (reg_off_i)
      `ADDER_A_OFF:   rdata_o = a_q;
      `ADDER_B_OFF:   rdata_o = b_q;
      `ADDER_SUM_OFF: rdata_o = sum;
      default:        rdata_o = '0;
    endcase
  end

endmodule : add_two_number

`default_nettype wire

/* logic/gpio_regs.sv */
// -----------------------------
// GPIO register block with per-pin level interrupts.
// Inputs pass a two-flop synchronizer first.
// -----------------------------
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module gpio_regs (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 sel_i,
  input  logic                 we_i,
  input  periph_pkg::reg_off_t reg_off_i,
  input  logic [31:0]          wdata_i,
  output logic [31:0]          rdata_o,

  input  logic [`GPIO_W-1:0]   gpio_i,
  output logic [`GPIO_W-1:0]   gpio_o,
  output logic [`GPIO_W-1:0]   gpio_oe_o,
  output logic [`GPIO_W-1:0]   gpio_irq_o
);

  localparam int PAD_W = 32 - `GPIO_W;

  logic [`GPIO_W-1:0] out_q;
  logic [`GPIO_W-1:0] oe_q;
  logic [`GPIO_W-1:0] ie_q;
  logic [`GPIO_W-1:0] sync_q1;
  logic [`GPIO_W-1:0] sync_q2;
  logic [`GPIO_W-1:0] status;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
    end
  end

  // IN and STATUS are read only
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
      ie_q  <= '0;
    end else if (sel_i && we_i) begin
      case (reg_off_i)
        `GPIO_OUT_OFF: out_q <= wdata_i[`GPIO_W-1:0];
        `GPIO_OE_OFF:  oe_q  <= wdata_i[`GPIO_W-1:0];
        `GPIO_IE_OFF:  ie_q  <= wdata_i[`GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  assign status = sync_q2 & ie_q;

  always_comb begin
    case (reg_off_i)
      `GPIO_OUT_OFF:    rdata_o = {{PAD_W{1'b0}}, out_q};
      `GPIO_OE_OFF:     rdata_o = {{PAD_W{1'b0}}, oe_q};
      `GPIO_IN_OFF:     rdata_o = {{PAD_W{1'b0}}, sync_q2};
      `GPIO_IE_OFF:     rdata_o = {{PAD_W{1'b0}}, ie_q};
      `GPIO_STATUS_OFF: rdata_o = {{PAD_W{1'b0}}, status};
      default:          rdata_o = '0;
    endcase
  end

  assign gpio_o     = out_q;
  assign gpio_oe_o  = oe_q;
  assign gpio_irq_o = status;

endmodule : gpio_regs

`default_nettype wire

/* logic/periph_decoder.sv */
// -----------------------------
// Address decode to peripheral selects and read-data mux.
// Bad addresses answer with the error pattern.
// -----------------------------
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module periph_decoder (
  input  logic                     acc_valid_i,
  input  logic                     acc_we_i,
  input  periph_pkg::periph_addr_u acc_addr_i,
  input  logic [31:0]              acc_wdata_i,

  output logic                     sel_gpio_o,
  output logic                     sel_adder_o,
  output logic                     sel_irq_o,
  output logic                     we_o,
  output periph_pkg::reg_off_t     reg_off_o,
  output logic [31:0]              wdata_o,

  input  logic [31:0]              gpio_rdata_i,
  input  logic [31:0]              adder_rdata_i,
  input  logic [31:0]              irq_rdata_i,

  output logic [31:0]              rsp_rdata_o,
  output logic                     rsp_err_o
);

  import periph_pkg::*;

  periph_sel_t sel;
  logic        base_ok;
  logic        sel_ok;
  logic        align_ok;
  logic        dec_err;

  assign sel      = acc_addr_i.fields.sel;
  assign base_ok  = (acc_addr_i.fields.base == `PERIPH_BASE);
  assign sel_ok   = (sel == `GPIO_IDX) || (sel == `ADDER_IDX) || (sel == `IRQ_IDX);
  assign align_ok = (acc_addr_i.fields.byte_off == 2'b00);
  assign dec_err  = ~(base_ok & sel_ok & align_ok);

  // At most one select per access, none on error
  assign sel_gpio_o  = acc_valid_i & ~dec_err & (sel == `GPIO_IDX);
  assign sel_adder_o = acc_valid_i & ~dec_err & (sel == `ADDER_IDX);
  assign sel_irq_o   = acc_valid_i & ~dec_err & (sel == `IRQ_IDX);

  assign we_o      = acc_we_i;
  assign reg_off_o = acc_addr_i.fields.off;
  assign wdata_o   = acc_wdata_i;

  always_comb begin
    rsp_rdata_o = `DECERR_DATA;
    if (!dec_err) begin
      case (sel)
        `GPIO_IDX:  rsp_rdata_o = gpio_rdata_i;
        `ADDER_IDX: rsp_rdata_o = adder_rdata_i;
        `IRQ_IDX:   rsp_rdata_o = irq_rdata_i;
        default:    rsp_rdata_o = `DECERR_DATA;
      endcase
    end
  end

  assign rsp_err_o = dec_err;

endmodule : periph_decoder

`default_nettype wire

/* logic/obi_reg_bridge.sv */
// -----------------------------
// OBI-style slave port to a one-cycle register access.
// One access in flight; response comes the cycle after grant.
// -----------------------------
`timescale 1ns/100ps
`default_nettype none

module obi_reg_bridge (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [31:0]            addr_i,
  input  logic [31:0]            wdata_i,
  output logic                   gnt_o,

  output logic                   acc_valid_o,
  output logic                   acc_we_o,
  output periph_pkg::periph_addr_u acc_addr_o,
  output logic [31:0]            acc_wdata_o,

  input  logic [31:0]            rsp_rdata_i,
  input  logic                   rsp_err_i,

  output logic                   rvalid_o,
  output logic [31:0]            rdata_o,
  output logic                   err_o
);

  import periph_pkg::*;

  logic         pending_q;
  logic         accept;
  logic         we_q;
  periph_addr_u addr_q;
  logic [31:0]  wdata_q;

  // Grant is withdrawn while an access is being served
  assign gnt_o  = ~pending_q;
  assign accept = req_i & gnt_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= accept;
    end
  end

  // Request payload, captured on the granted cycle
  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q       <= we_i;
      addr_q.raw <= addr_i;
      wdata_q    <= wdata_i;
    end
  end

  assign acc_valid_o = pending_q;
  assign acc_we_o    = we_q;
  assign acc_addr_o  = addr_q;
  assign acc_wdata_o = wdata_q;

  // Decoder answers combinationally in the pending cycle
  assign rvalid_o = pending_q;
  assign rdata_o  = rsp_rdata_i;
  assign err_o    = rsp_err_i;

endmodule : obi_reg_bridge

`default_nettype wire

/* logic/periph_pkg.sv */
// -----------------------------
// Types shared by the peripheral subsystem RTL.
// Import where address fields or offsets are handled.
// -----------------------------
`default_nettype none

package periph_pkg;

  typedef logic [15:0] base_page_t;
  typedef logic [3:0]  periph_sel_t;
  typedef logic [9:0]  reg_off_t;
  typedef logic [1:0]  byte_off_t;

  // Field layout of a bus address, MSB first
  typedef struct packed {
    base_page_t  base;
    periph_sel_t sel;
    reg_off_t    off;
    byte_off_t   byte_off;
  } periph_addr_fields_t;

  // Same address word, seen raw or split into fields
  typedef union packed {
    logic [31:0]         raw;
    periph_addr_fields_t fields;
  } periph_addr_u;

endpackage : periph_pkg

`default_nettype wire

/* logic/periph_params.svh */
// -----------------------------
// Address map, register offsets and widths.
// Include in any file that needs them.
// -----------------------------
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

`define PERIPH_BASE 16'h2000
`define GPIO_IDX    4'd0
`define ADDER_IDX   4'd1
`define IRQ_IDX     4'd2

`define GPIO_W      8
`define EXT_IRQ_W   4

`define GPIO_OUT_OFF    10'd0
`define GPIO_OE_OFF     10'd1
`define GPIO_IN_OFF     10'd2
`define GPIO_IE_OFF     10'd3
`define GPIO_STATUS_OFF 10'd4

`define ADDER_A_OFF   10'd0
`define ADDER_B_OFF   10'd1
`define ADDER_SUM_OFF 10'd2

`define IRQ_IE_OFF      10'd0
`define IRQ_PENDING_OFF 10'd1
`define IRQ_CLAIM_OFF   10'd2
`define IRQ_MSIP_OFF    10'd3

`define DECERR_DATA 32'hdead_beef

`endif
